/* verification/decodeInput.txt */
// ir gap(0 none,1 idle,2 reset) regs{ra,rb,rc,rt} {rfWrite,isExi} imm
// mem{load,store,zext,size,multi} flow{jmp,jxx,jxz,bra,rts,flowChange} branchDisp
000084188202 0 02030401 10 0000000000000000 00030 000000 0000000000000000
000208398A02 0 06070805 10 0000000000000000 00031 000000 0000000000000000
000260000002 1 00000000 10 0000000000000000 00031 000000 0000000000000000
C00000010604 0 04000003 10 FFFFFFFFFFFFF800 00030 000000 0000000000000000
091800004209 0 01000001 10 FFFFFFFFFFFFE123 00030 000000 0000000000000000
FFF80000040A 0 00000002 10 0000000000001FFF 00030 000000 0000000000000000
800000008E14 0 02000007 10 FFFFFFFFF0000000 00030 000000 0000000000000000
000000280219 0 00050001 10 FFFFFFFFE0000005 00030 000000 0000000000000000
00000150060D 1 000A0103 10 000000000000002A 00030 000000 0000000000000000
00000000FE50 0 03000000 01 0000000000000000 00030 000000 0000000000000000
002800000204 1 00000001 10 FFFFFFFFFE000005 00030 000000 0000000000000000
002800000204 0 00000001 10 0000000000000005 00030 000000 0000000000000000
00002468AC53 0 020D0400 01 0000000000000000 00030 000000 0000000000000000
00000018041A 1 00030002 10 00002468AD000003 00030 000000 0000000000000000
FFFFFFFFFE54 0 1F1F1F00 01 0000000000000000 00030 000000 0000000000000000
000000814883 1 05100004 10 FFFFFFFFFE000010 10111 000000 0000000000000000
FFFFFFF85290 0 011F0900 00 FFFFFFFFFFFFFFFF 01001 000000 0000000000000000
000000000286 0 00000001 10 0000000000000000 10031 000000 0000000000000000
000010000821 0 00001000 00 0000000000000000 00030 000101 FFFFFFFFFFFC0002
002460188026 0 02030000 00 0000000000000000 00030 010001 0000000000000246
00001FF8FC2A 0 031F1F00 00 0000000000000000 00030 001001 FFFFFFFFFFFFFFFC
000000000220 0 00000000 00 0000000000000000 00030 100001 0000000000000002
0000000006FF 0 00000003 00 0000000000000000 00030 000000 0000000000000000
000000000251 0 00000000 01 0000000000000000 00030 000000 0000000000000000
000000280C0C 2 00050006 10 0000000000000005 00030 000000 0000000000000000

/* sim.f */
logic/decodePkg.sv
logic/prefixTracker.sv
logic/regFieldDecoder.sv
logic/immediateGenerator.sv
logic/memOpClassifier.sv
logic/flowDecoder.sv
logic/decodeStage.sv
verification/decodeStage_sva.sv
verification/decodeStageTb.sv

/* Bender.yml */
package:
  name: decodeStage

sources:
  - logic/decodePkg.sv
  - logic/prefixTracker.sv
  - logic/regFieldDecoder.sv
  - logic/immediateGenerator.sv
  - logic/memOpClassifier.sv
  - logic/flowDecoder.sv
  - logic/decodeStage.sv
  - target: simulation
    files:
      - verification/decodeStage_sva.sv
      - verification/decodeStageTb.sv

/* verification/decodeStageTb.sv */
// Testbench for the decode stage, driven from a vector file of words and expected results
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb import decodePkg::*;;

	localparam int NumRecords = 25;
	localparam int WordsPerRecord = 8;
	localparam int WaitLimit = 10;

	logic clk;
	logic rst;
	logic irValid;
	Instruction ir;
	logic decoValid;
	RegIdx ra, rb, rc, rt;
	logic rfWrite;
	logic [63:0] imm;
	logic isExi;
	logic load, store, loadZeroExt, multiCycle;
	MemSize memSize;
	logic jmp, jxx, jxz, bra, rts, flowChange;
	logic [63:0] branchDisp;

	logic [63:0] vectors [0:NumRecords*WordsPerRecord-1];
	integer seed;

	decodeStage #(.ValueWidth(64)) decodeStage_i (
		.clk(clk), .rst(rst), .irValid(irValid), .ir(ir),
		.decoValid(decoValid), .ra(ra), .rb(rb), .rc(rc), .rt(rt), .rfWrite(rfWrite),
		.imm(imm), .isExi(isExi),
		.load(load), .store(store), .loadZeroExt(loadZeroExt), .memSize(memSize),
		.multiCycle(multiCycle),
		.jmp(jmp), .jxx(jxx), .jxz(jxz), .bra(bra), .rts(rts), .flowChange(flowChange),
		.branchDisp(branchDisp)
	);

	always #10 clk = ~clk;

	// ==================================================
	// Reporting
	// ==================================================
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (expected === actual)
		else
			failRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	// Watch the bound protocol checker just after each edge
	always @(posedge clk)
	begin
		#1;
		assert (decodeStage_i.decodeStageSva_i.failCount == 0)
		else
			failRun("A protocol assertion on the decode stage outputs failed");
	end

	// Hold reset and watch that nothing comes out meanwhile
	task automatic applyReset(input int cycles);
		rst = 1'b1;
		irValid = 1'b0;
		repeat (cycles)
		begin
			@(posedge clk);
			#2;
			assert (decoValid === 1'b0)
			else
				failRun("decoValid was high while reset was asserted");
		end
		rst = 1'b0;
	endtask

	task automatic compareOutputs(input int idx);
		logic [63:0] regs, rfx, mem, flow;
		string tag;
		regs = vectors[idx*WordsPerRecord+2];
		rfx = vectors[idx*WordsPerRecord+3];
		mem = vectors[idx*WordsPerRecord+5];
		flow = vectors[idx*WordsPerRecord+6];
		tag = $sformatf("record %0d", idx);
		checkValue({tag, " ra"}, regs[31:24], ra);
		checkValue({tag, " rb"}, regs[23:16], rb);
		checkValue({tag, " rc"}, regs[15:8], rc);
		checkValue({tag, " rt"}, regs[7:0], rt);
		checkValue({tag, " rfWrite"}, rfx[4], rfWrite);
		checkValue({tag, " isExi"}, rfx[0], isExi);
		checkValue({tag, " imm"}, vectors[idx*WordsPerRecord+4], imm);
		checkValue({tag, " load"}, mem[16], load);
		checkValue({tag, " store"}, mem[12], store);
		checkValue({tag, " loadZeroExt"}, mem[8], loadZeroExt);
		checkValue({tag, " memSize"}, mem[5:4], memSize);
		checkValue({tag, " multiCycle"}, mem[0], multiCycle);
		checkValue({tag, " jmp"}, flow[20], jmp);
		checkValue({tag, " jxx"}, flow[16], jxx);
		checkValue({tag, " jxz"}, flow[12], jxz);
		checkValue({tag, " bra"}, flow[8], bra);
		checkValue({tag, " rts"}, flow[4], rts);
		checkValue({tag, " flowChange"}, flow[0], flowChange);
		checkValue({tag, " branchDisp"}, vectors[idx*WordsPerRecord+7], branchDisp);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial
	begin
		int gapLen;
		int waitCount;
		logic [63:0] gapReq;
		clk = 1'b0;
		rst = 1'b1;
		irValid = 1'b0;
		ir = '0;
		seed = 32'hd3d8;
		$readmemh("verification/decodeInput.txt", vectors);
		if (vectors[NumRecords*WordsPerRecord-1] === 64'bx)
			failRun("The vector file could not be read completely");
		repeat (8)
			@(posedge clk);
		#2;
		rst = 1'b0;

		for (int idx = 0; idx < NumRecords; idx++)
		begin
			gapReq = vectors[idx*WordsPerRecord+1];
			// 1 asks for an idle gap, 2 for a fresh reset
			if (gapReq == 64'd1)
			begin
				irValid = 1'b0;
				gapLen = $unsigned($random(seed)) % 4;
				repeat (gapLen)
				begin
					@(posedge clk);
					#2;
				end
			end
			else if (gapReq == 64'd2)
				applyReset(3);
			ir = vectors[idx*WordsPerRecord][47:0];
			irValid = 1'b1;
			@(posedge clk);
			#2;
			waitCount = 0;
			while (decoValid !== 1'b1)
			begin
				if (waitCount >= WaitLimit)
					failRun($sformatf("decoValid never came for record %0d", idx));
				irValid = 1'b0;
				@(posedge clk);
				#2;
				waitCount++;
			end
			compareOutputs(idx);
		end
		irValid = 1'b0;
		@(posedge clk);
		#2;
		$display("Simulation passed");
		$finish;
	end

	initial
	begin
		#100000;
		failRun("The simulation ran far longer than expected");
	end

endmodule

`default_nettype wire

/* verification/decodeStage_sva.sv */
// Protocol assertions for the decode stage outputs, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module decodeStageSva (
	input wire logic clk,
	input wire logic rst,
	input wire logic irValid,
	input wire logic decoValid,
	input wire logic isExi,
	input wire logic rfWrite,
	input wire logic load,
	input wire logic store
);

	// Running count of failed assertions, watched by the testbench
	int failCount = 0;

	// Output strobe is cleared by reset
	assert property (@(posedge clk) rst |=> !decoValid)
	else
	begin
		$error("decoValid high after a reset cycle");
		failCount++;
	end

	// One cycle from accept to result
	assert property (@(posedge clk) disable iff (rst) 1'b1 |=> decoValid == $past(irValid))
	else
	begin
		$error("decoValid does not follow irValid by one cycle");
		failCount++;
	end

	assert property (@(posedge clk) disable iff (rst) isExi |-> !rfWrite)
	else
	begin
		$error("prefix word decoded with a register write");
		failCount++;
	end

	assert property (@(posedge clk) disable iff (rst) !(load && store))
	else
	begin
		$error("load and store both set");
		failCount++;
	end

endmodule

bind decodeStage decodeStageSva decodeStageSva_i (
	.clk(clk), .rst(rst), .irValid(irValid), .decoValid(decoValid),
	.isExi(isExi), .rfWrite(rfWrite), .load(load), .store(store)
);

`default_nettype wire

/* logic/decodeStage.sv */
// Registered instruction decode stage for 48-bit instruction words
`timescale 1ns/1ns
`default_nettype none

module decodeStage import decodePkg::*; #(
	parameter int ValueWidth = DefaultValueWidth
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic irValid,
	input wire Instruction ir,
	output logic decoValid,
	output RegIdx ra,
	output RegIdx rb,
	output RegIdx rc,
	output RegIdx rt,
	output logic rfWrite,
	output logic [ValueWidth-1:0] imm,
	output logic isExi,
	output logic load,
	output logic store,
	output logic loadZeroExt,
	output MemSize memSize,
	output logic multiCycle,
	output logic jmp,
	output logic jxx,
	output logic jxz,
	output logic bra,
	output logic rts,
	output logic flowChange,
	output logic [ValueWidth-1:0] branchDisp
);

	logic exiNow;
	logic prefixPending;
	logic [39:0] prefixPayload;
	ExiWidth prefixWidthSel;
	RegIdx decRa, decRb, decRc, decRt;
	logic decRfWrite;
	logic [ValueWidth-1:0] decImm;
	logic decLoad, decStore, decLoadZeroExt, decMultiCycle;
	MemSize decMemSize;
	logic decJmp, decJxx, decJxz, decBra, decRts, decFlowChange;
	logic [ValueWidth-1:0] decBranchDisp;

	// ==================================================
	// Decoders
	// ==================================================
	prefixTracker prefixTracker_i (
		.clk(clk), .rst(rst), .irValid(irValid), .ir(ir),
		.isExi(exiNow), .prefixPending(prefixPending),
		.prefixPayload(prefixPayload), .prefixWidthSel(prefixWidthSel)
	);

	regFieldDecoder regFieldDecoder_i (
		.ir(ir), .isExi(exiNow),
		.ra(decRa), .rb(decRb), .rc(decRc), .rt(decRt), .rfWrite(decRfWrite)
	);

	immediateGenerator #(.ValueWidth(ValueWidth)) immediateGenerator_i (
		.ir(ir), .prefixPending(prefixPending), .prefixPayload(prefixPayload),
		.prefixWidthSel(prefixWidthSel), .imm(decImm)
	);

	memOpClassifier memOpClassifier_i (
		.ir(ir), .load(decLoad), .store(decStore), .loadZeroExt(decLoadZeroExt),
		.memSize(decMemSize), .multiCycle(decMultiCycle)
	);

	flowDecoder #(.ValueWidth(ValueWidth)) flowDecoder_i (
		.ir(ir), .jmp(decJmp), .jxx(decJxx), .jxz(decJxz), .bra(decBra),
		.rts(decRts), .flowChange(decFlowChange), .branchDisp(decBranchDisp)
	);

	// ==================================================
	// Output registers
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decoValid <= 1'b0;
			rfWrite <= 1'b0;
			isExi <= 1'b0;
			load <= 1'b0;
			store <= 1'b0;
			loadZeroExt <= 1'b0;
			multiCycle <= 1'b0;
			jmp <= 1'b0;
			jxx <= 1'b0;
			jxz <= 1'b0;
			bra <= 1'b0;
			rts <= 1'b0;
			flowChange <= 1'b0;
		end
		else
		begin
			decoValid <= irValid;
			if (irValid)
			begin
				rfWrite <= decRfWrite;
				isExi <= exiNow;
				load <= decLoad;
				store <= decStore;
				loadZeroExt <= decLoadZeroExt;
				multiCycle <= decMultiCycle;
				jmp <= decJmp;
				jxx <= decJxx;
				jxz <= decJxz;
				bra <= decBra;
				rts <= decRts;
				flowChange <= decFlowChange;
			end
		end
	end

	// Data fields just follow the accepted word
	always_ff @(posedge clk)
	begin
		if (irValid)
		begin
			ra <= decRa;
			rb <= decRb;
			rc <= decRc;
			rt <= decRt;
			imm <= decImm;
			memSize <= decMemSize;
			branchDisp <= decBranchDisp;
		end
	end

endmodule

`default_nettype wire

/* logic/flowDecoder.sv */
// Flow change classification and branch displacement extraction
`timescale 1ns/1ns
`default_nettype none

module flowDecoder import decodePkg::*; #(
	parameter int ValueWidth = DefaultValueWidth
) (
	input wire Instruction ir,
	output logic jmp,
	output logic jxx,
	output logic jxz,
	output logic bra,
	output logic rts,
	output logic flowChange,
	output logic [ValueWidth-1:0] branchDisp
);

	Opcode opcode;

	assign opcode = Opcode'(ir[7:0]);

	assign jmp = opcode == JMP;
	assign bra = opcode == BRA;
	assign rts = opcode == RTS;
	assign jxx = (opcode == JEQ) || (opcode == JNE) || (opcode == JLT) || (opcode == JGE);
	assign jxz = (opcode == JEQZ) || (opcode == JNEZ);
	assign flowChange = jmp | jxx | jxz | bra | rts;

	// Displacements count halfwords, so shift left by one
	always_comb
	begin
		if (bra)
			branchDisp = {{(ValueWidth-19){ir[28]}}, ir[28:11], 1'b0};
		else if (jxx)
			branchDisp = {{(ValueWidth-20){ir[47]}}, ir[47:29], 1'b0};
		else if (jxz)
			// Target split around the Ra field
			branchDisp = {{(ValueWidth-16){ir[28]}}, ir[28:19], ir[13:9], 1'b0};
		else if (jmp)
			branchDisp = {{(ValueWidth-40){ir[47]}}, ir[47:9], 1'b0};
		else
			branchDisp = '0;
	end

endmodule

`default_nettype wire

/* logic/memOpClassifier.sv */
// Load and store classification, access size and multi-cycle detection
`timescale 1ns/1ns
`default_nettype none

module memOpClassifier import decodePkg::*; (
	input wire Instruction ir,
	output logic load,
	output logic store,
	output logic loadZeroExt,
	output MemSize memSize,
	output logic multiCycle
);

	Opcode opcode;
	R2Func func;
	logic arithMulti;

	assign opcode = Opcode'(ir[7:0]);
	assign func = R2Func'(ir[FuncLsb +: FuncWidth]);

	always_comb
	begin
		load = 1'b0;
		store = 1'b0;
		loadZeroExt = 1'b0;
		memSize = Octa;
		case (opcode)
		LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO:
			load = 1'b1;
		STB, STW, STT, STO:
			store = 1'b1;
		default:
			;
		endcase
		case (opcode)
		LDBU, LDWU, LDTU:
			loadZeroExt = 1'b1;
		default:
			;
		endcase
		case (opcode)
		LDB, LDBU, STB:		memSize = Byte;
		LDW, LDWU, STW:		memSize = Wyde;
		LDT, LDTU, STT:		memSize = Tetra;
		default:			memSize = Octa;
		endcase
	end

	// Multiply and divide go to the iterative unit
	always_comb
	begin
		case (opcode)
		MULI, DIVI:
			arithMulti = 1'b1;
		R2:
			arithMulti = (func == MUL) || (func == DIV);
		default:
			arithMulti = 1'b0;
		endcase
	end

	assign multiCycle = arithMulti | load | store;

endmodule

`default_nettype wire

/* logic/immediateGenerator.sv */
// Immediate constant builder with EXI prefix extension
`timescale 1ns/1ns
`default_nettype none

module immediateGenerator import decodePkg::*; #(
	parameter int ValueWidth = DefaultValueWidth
) (
	input wire Instruction ir,
	input wire logic prefixPending,
	input wire logic [39:0] prefixPayload,
	input wire ExiWidth prefixWidthSel,
	output logic [ValueWidth-1:0] imm
);

	// Prefix payload lands above the low 24 bits
	localparam int ExtWidth = ValueWidth - 24;

	Opcode opcode;
	logic [ImmRiWidth-1:0] riImm;
	logic [ImmRilWidth-1:0] rilImm;
	logic [ShAmtWidth-1:0] shAmt;
	logic [ValueWidth-1:0] baseImm;
	logic [ExtWidth-1:0] extPayload;

	assign opcode = Opcode'(ir[7:0]);
	assign riImm = ir[ImmRiLsb +: ImmRiWidth];
	assign rilImm = ir[ImmRilLsb +: ImmRilWidth];
	assign shAmt = ir[ShAmtLsb +: ShAmtWidth];

	always_comb
	begin
		case (opcode)
		ADDI, CMPI, SLTI, MULI, DIVI:
			baseImm = {{(ValueWidth-ImmRiWidth){riImm[ImmRiWidth-1]}}, riImm};
		// Ones to the left so the mask keeps the upper bits
		ANDI:
			baseImm = {{(ValueWidth-ImmRiWidth){1'b1}}, riImm};
		ORI, XORI:
			baseImm = {{(ValueWidth-ImmRiWidth){1'b0}}, riImm};
		ADDIL:
			baseImm = {{(ValueWidth-ImmRilWidth){rilImm[ImmRilWidth-1]}}, rilImm};
		ANDIL:
			baseImm = {{(ValueWidth-ImmRilWidth){1'b1}}, rilImm};
		ORIL, XORIL:
			baseImm = {{(ValueWidth-ImmRilWidth){1'b0}}, rilImm};
		// Memory displacement
		LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO,
		STB, STW, STT, STO:
			baseImm = {{(ValueWidth-ImmRilWidth){rilImm[ImmRilWidth-1]}}, rilImm};
		SLLI, SRLI, SRAI:
			baseImm = {{(ValueWidth-ShAmtWidth){1'b0}}, shAmt};
		default:
			baseImm = '0;
		endcase
	end

	// Sign extend the payload from its own top bit
	always_comb
	begin
		case (prefixWidthSel)
		Exi8:
			extPayload = ExtWidth'($signed(prefixPayload[7:0]));
		Exi24:
			extPayload = ExtWidth'($signed(prefixPayload[23:0]));
		default:
			extPayload = ExtWidth'($signed(prefixPayload));
		endcase
	end

	assign imm = prefixPending ? {extPayload, baseImm[23:0]} : baseImm;

endmodule

`default_nettype wire

/* logic/regFieldDecoder.sv */
// Register specifier extraction and register file write enable
`timescale 1ns/1ns
`default_nettype none

module regFieldDecoder import decodePkg::*; (
	input wire Instruction ir,
	input wire logic isExi,
	output RegIdx ra,
	output RegIdx rb,
	output RegIdx rc,
	output RegIdx rt,
	output logic rfWrite
);

	Opcode opcode;

	assign opcode = Opcode'(ir[7:0]);

	assign ra = ir[RaLsb +: $bits(RegIdx)];
	assign rb = ir[RbLsb +: $bits(RegIdx)];

	always_comb
	begin
		// Stores carry the source register in the Rt slot
		case (opcode)
		STB, STW, STT, STO:
			rc = ir[RtLsb +: $bits(RegIdx)];
		default:
			rc = ir[RcLsb +: $bits(RegIdx)];
		endcase

		// No target for stores and flow changes
		case (opcode)
		STB, STW, STT, STO,
		JMP, BRA, JEQ, JNE, JLT, JGE, JEQZ, JNEZ, RTS:
			rt = '0;
		default:
			rt = isExi ? '0 : ir[RtLsb +: $bits(RegIdx)];
		endcase

		case (opcode)
		R2, R3:
			rfWrite = 1'b1;
		ADDI, CMPI, SLTI, MULI, DIVI, ANDI, ORI, XORI:
			rfWrite = 1'b1;
		ADDIL, ANDIL, ORIL, XORIL:
			rfWrite = 1'b1;
		SLLI, SRLI, SRAI:
			rfWrite = 1'b1;
		LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO:
			rfWrite = 1'b1;
		default:
			rfWrite = 1'b0;
		endcase
		if (isExi)
			rfWrite = 1'b0;
	end

endmodule

`default_nettype wire

/* logic/prefixTracker.sv */
// EXI prefix detection and storage of the pending extension payload
`timescale 1ns/1ns
`default_nettype none

module prefixTracker import decodePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic irValid,
	input wire Instruction ir,
	output logic isExi,
	output logic prefixPending,
	output logic [39:0] prefixPayload,
	output ExiWidth prefixWidthSel
);

	Opcode opcode;
	ExiWidth curWidth;
	logic [39:0] curPayload;

	assign opcode = Opcode'(ir[7:0]);

	// Payload is the field above the opcode with opcode bit 0 appended
	always_comb
	begin
		isExi = 1'b1;
		curWidth = Exi40;
		curPayload = {ir[47:9], ir[0]};
		case (opcode)
		EXI8, EXI8B:
		begin
			curWidth = Exi8;
			curPayload = {32'd0, ir[15:9], ir[0]};
		end
		EXI24, EXI24B:
		begin
			curWidth = Exi24;
			curPayload = {16'd0, ir[31:9], ir[0]};
		end
		EXI40, EXI40B:
			curWidth = Exi40;
		default:
			isExi = 1'b0;
		endcase
	end

	// Any accepted word replaces or consumes the prefix
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prefixPending <= 1'b0;
			prefixWidthSel <= Exi8;
		end
		else if (irValid)
		begin
			prefixPending <= isExi;
			if (isExi)
				prefixWidthSel <= curWidth;
		end
	end

	always_ff @(posedge clk)
	begin
		if (irValid && isExi)
			prefixPayload <= curPayload;
	end

endmodule

`default_nettype wire

/* logic/decodePkg.sv */
// Instruction set definitions shared by the decode stage blocks
`default_nettype none

package decodePkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int InstrWidth = 48;
	localparam int DefaultValueWidth = 64;

	typedef logic [InstrWidth-1:0] Instruction;
	typedef logic [4:0] RegIdx;

	// ==================================================
	// Field positions
	// ==================================================
	localparam int RtLsb = 9;
	localparam int RaLsb = 14;
	localparam int RbLsb = 19;
	localparam int RcLsb = 24;
	localparam int FuncLsb = 29;
	localparam int FuncWidth = 7;
	localparam int ImmRiLsb = 35;
	localparam int ImmRiWidth = 13;
	// RIL immediate and memory displacement share this field
	localparam int ImmRilLsb = 19;
	localparam int ImmRilWidth = 29;
	localparam int ShAmtLsb = 19;
	localparam int ShAmtWidth = 6;

	// ==================================================
	// Opcodes and functions
	// ==================================================
	typedef enum logic [7:0] {
		R2 = 8'h02, R3 = 8'h03,
		ADDI = 8'h04, CMPI = 8'h05, SLTI = 8'h06, MULI = 8'h07,
		DIVI = 8'h08, ANDI = 8'h09, ORI = 8'h0A, XORI = 8'h0B,
		SLLI = 8'h0C, SRLI = 8'h0D, SRAI = 8'h0E,
		ADDIL = 8'h14, ANDIL = 8'h19, ORIL = 8'h1A, XORIL = 8'h1B,
		JMP = 8'h20, BRA = 8'h21,
		JEQ = 8'h26, JNE = 8'h27, JLT = 8'h28, JGE = 8'h29,
		JEQZ = 8'h2A, JNEZ = 8'h2B, RTS = 8'h2C,
		// Prefix pairs, B form has bit 0 set
		EXI8 = 8'h50, EXI8B = 8'h51,
		EXI24 = 8'h52, EXI24B = 8'h53,
		EXI40 = 8'h54, EXI40B = 8'h55,
		LDB = 8'h80, LDBU = 8'h81, LDW = 8'h82, LDWU = 8'h83,
		LDT = 8'h84, LDTU = 8'h85, LDO = 8'h86,
		STB = 8'h90, STW = 8'h91, STT = 8'h92, STO = 8'h93
	} Opcode;

	typedef enum logic [FuncWidth-1:0] {
		ADD = 7'h04,
		SUB = 7'h05,
		AND = 7'h08,
		OR = 7'h09,
		MUL = 7'h10,
		DIV = 7'h13
	} R2Func;

	typedef enum logic [1:0] {
		Byte = 2'd0,
		Wyde = 2'd1,
		Tetra = 2'd2,
		Octa = 2'd3
	} MemSize;

	// Size of a pending prefix payload
	typedef enum logic [1:0] {
		Exi8 = 2'd0,
		Exi24 = 2'd1,
		Exi40 = 2'd2
	} ExiWidth;

endpackage

`default_nettype wire
